//--- bus_fabric.sv
`timescale 1ns/1ns
`default_nettype none

module bus_fabric import soc_pkg::*; (
	input wire clk,
	input wire rst_i,
	input wire bus_req_t bus_req_i,
	output unit_sel_t sel_o,
	output logic [REG_IDX_W-1:0] idx_o,
	output logic rd_o,
	output logic wr_o,
	output logic [DATA_W-1:0] wdat_o,
	input wire [DATA_W-1:0] bdatr_idrg_i,
	input wire [DATA_W-1:0] bdatr_port_i,
	input wire [DATA_W-1:0] bdatr_tim0_i,
	output logic [DATA_W-1:0] bdatr_o
);

	logic [UNIT_ADR_W-1:0] unit_adr; // Upper address field
	logic acc; // Any access this cycle

	assign unit_adr = bus_req_i.adr[REG_IDX_W +: UNIT_ADR_W];
	assign acc = bus_req_i.rd | bus_req_i.wr;

	// Selects stay quiet between accesses
	always_comb begin
		sel_o.idrg = acc && (unit_adr == BASE_IDRG);
		sel_o.port = acc && (unit_adr == BASE_PORT);
		sel_o.tim0 = acc && (unit_adr == BASE_TIM0);
	end

	assign idx_o = bus_req_i.adr[REG_IDX_W-1:0]; // Register index, unit decodes it
	assign rd_o = bus_req_i.rd;
	assign wr_o = bus_req_i.wr;
	assign wdat_o = bus_req_i.dat;

	// Unselected units hold zero, so a plain OR merges them
	assign bdatr_o = bdatr_idrg_i | bdatr_port_i | bdatr_tim0_i;

	a_rd_wr_excl: assert property (@(posedge clk) disable iff (rst_i)
		!(bus_req_i.rd && bus_req_i.wr)); // Master never issues both strobes

	a_sel_onehot: assert property (@(posedge clk) disable iff (rst_i)
		$onehot0(sel_o)); // Bases never overlap

endmodule

`default_nettype wire

//--- filelist.f
soc_pkg.sv
bus_fabric.sv
id_regs.sv
port_unit.sv
timer_fsm.sv
timer_counter.sv
timer_unit.sv
periph_top.sv
tb_periph_top.sv

//--- id_regs.sv
`timescale 1ns/1ns
`default_nettype none

module id_regs import soc_pkg::*; (
	input wire clk,
	input wire rst_i,
	input wire sel_i,
	input wire rd_i,
	input wire [REG_IDX_W-1:0] idx_i,
	output logic [DATA_W-1:0] bdatr_o
);

	always_ff @(posedge clk) begin
		if (rst_i) begin
			bdatr_o <= '0;
		end else if (sel_i && rd_i) begin
			case (idx_i)
				IDRG_ID:  bdatr_o <= ID_CODE; // Chip family code
				IDRG_VER: bdatr_o <= VERSION; // Release number
				IDRG_KHZ: bdatr_o <= CLK_KHZ; // Clock rate for software delays
				default:  bdatr_o <= '0; // Unused offsets read zero
			endcase
		end else begin
			bdatr_o <= '0; // Idle or other unit, stay off the OR bus
		end
	end

endmodule

`default_nettype wire

//--- periph_top.sv
`timescale 1ns/1ns
`default_nettype none

module periph_top import soc_pkg::*; #(
	parameter int PORT_W = 8, // Port width, matches the pad struct
	parameter int CNT_W = 16  // Timer counter width
) (
	input wire clk,
	input wire rst_i,
	input wire bus_req_t bus_req_i,
	output logic [DATA_W-1:0] bdatr_o,
	input wire [2*PORT_W-1:0] port_pin_i,
	output port_pads_t port_pads_o,
	output logic tim0_pwma_o,
	output logic tim0_pwmb_o,
	output logic tim0_irq_o
);

	unit_sel_t sel; // One select per unit
	logic [REG_IDX_W-1:0] idx;
	logic rd;
	logic wr;
	logic [DATA_W-1:0] wdat;
	logic [DATA_W-1:0] bdatr_idrg;
	logic [DATA_W-1:0] bdatr_port;
	logic [DATA_W-1:0] bdatr_tim0;

	bus_fabric i_fabric (
		.clk(clk),
		.rst_i(rst_i),
		.bus_req_i(bus_req_i),
		.sel_o(sel),
		.idx_o(idx),
		.rd_o(rd),
		.wr_o(wr),
		.wdat_o(wdat),
		.bdatr_idrg_i(bdatr_idrg),
		.bdatr_port_i(bdatr_port),
		.bdatr_tim0_i(bdatr_tim0),
		.bdatr_o(bdatr_o)
	);

	id_regs i_idrg (
		.clk(clk),
		.rst_i(rst_i),
		.sel_i(sel.idrg),
		.rd_i(rd),
		.idx_i(idx),
		.bdatr_o(bdatr_idrg)
	);

	port_unit #(
		.PORT_W(PORT_W)
	) i_port (
		.clk(clk),
		.rst_i(rst_i),
		.sel_i(sel.port),
		.rd_i(rd),
		.wr_i(wr),
		.idx_i(idx),
		.wdat_i(wdat),
		.port_pin_i(port_pin_i),
		.port_pads_o(port_pads_o),
		.bdatr_o(bdatr_port)
	);

	timer_unit #(
		.CNT_W(CNT_W)
	) i_tim0 (
		.clk(clk),
		.rst_i(rst_i),
		.sel_i(sel.tim0),
		.rd_i(rd),
		.wr_i(wr),
		.idx_i(idx),
		.wdat_i(wdat),
		.pwma_o(tim0_pwma_o),
		.pwmb_o(tim0_pwmb_o),
		.tim_irq_o(tim0_irq_o),
		.bdatr_o(bdatr_tim0)
	);

endmodule

`default_nettype wire

//--- port_unit.sv
`timescale 1ns/1ns
`default_nettype none

module port_unit import soc_pkg::*; #(
	parameter int PORT_W = 8
) (
	input wire clk,
	input wire rst_i,
	input wire sel_i,
	input wire rd_i,
	input wire wr_i,
	input wire [REG_IDX_W-1:0] idx_i,
	input wire [DATA_W-1:0] wdat_i,
	input wire [2*PORT_W-1:0] port_pin_i,
	output port_pads_t port_pads_o,
	output logic [DATA_W-1:0] bdatr_o
);

	logic [PORT_W-1:0] out_q; // Output latch
	logic [PORT_W-1:0] enb_q; // Drive enable per bit
	logic [PORT_W-1:0] sel_q; // 1 picks the low pin, 0 the high pin
	logic [PORT_W-1:0] pin_lo;
	logic [PORT_W-1:0] pin_hi;
	logic [PORT_W-1:0] inp_mux; // Selected pin per bit
	logic [PORT_W-1:0] inp_q; // Sampled input, one cycle old

	assign pin_lo = port_pin_i[PORT_W-1:0];
	assign pin_hi = port_pin_i[2*PORT_W-1:PORT_W];
	assign inp_mux = (pin_lo & sel_q) | (pin_hi & ~sel_q); // Bit i from pin i or i+PORT_W

	// Control registers, pins high-Z out of reset
	always_ff @(posedge clk) begin
		if (rst_i) begin
			out_q <= '0;
			enb_q <= '0;
			sel_q <= '1; // Low pins by default
		end else if (sel_i && wr_i) begin
			case (idx_i)
				PORT_OUT: out_q <= wdat_i[PORT_W-1:0];
				PORT_ENB: enb_q <= wdat_i[PORT_W-1:0];
				PORT_SEL: sel_q <= wdat_i[PORT_W-1:0];
				default: ; // PORT_INP and unused offsets ignore writes
			endcase
		end
	end

	// Input synchronizer stage
	always_ff @(posedge clk) begin
		inp_q <= inp_mux;
	end

	// Registered read word
	always_ff @(posedge clk) begin
		if (rst_i) begin
			bdatr_o <= '0;
		end else if (sel_i && rd_i) begin
			case (idx_i)
				PORT_OUT: bdatr_o <= DATA_W'(out_q);
				PORT_ENB: bdatr_o <= DATA_W'(enb_q);
				PORT_SEL: bdatr_o <= DATA_W'(sel_q);
				PORT_INP: bdatr_o <= DATA_W'(inp_q);
				default:  bdatr_o <= '0;
			endcase
		end else begin
			bdatr_o <= '0;
		end
	end

	assign port_pads_o.out = out_q; // Pad model applies enb
	assign port_pads_o.enb = enb_q;

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the peripheral testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_periph_top \
	--Mdir obj_dir \
	-f filelist.f

# Exit status is nonzero when the run ends in $fatal
./obj_dir/Vtb_periph_top

//--- soc_pkg.sv
`default_nettype none

package soc_pkg;

	// Bus geometry
	localparam int DATA_W     = 16; // Read and write data width
	localparam int UNIT_ADR_W = 12; // Upper address bits that pick a unit
	localparam int REG_IDX_W  = 4;  // Low address bits, 16 registers per unit
	localparam int PORT_PAD_W = 8;  // Pad vector width of the port

	// Unit bases, upper 12 address bits
	localparam logic [UNIT_ADR_W-1:0] BASE_IDRG = 12'h010; // ID registers at 0x0100
	localparam logic [UNIT_ADR_W-1:0] BASE_PORT = 12'h011; // Port at 0x0110
	localparam logic [UNIT_ADR_W-1:0] BASE_TIM0 = 12'h012; // Timer 0 at 0x0120

	// ID block offsets
	localparam logic [REG_IDX_W-1:0] IDRG_ID  = 4'd0;
	localparam logic [REG_IDX_W-1:0] IDRG_VER = 4'd1;
	localparam logic [REG_IDX_W-1:0] IDRG_KHZ = 4'd2;

	// Port offsets
	localparam logic [REG_IDX_W-1:0] PORT_OUT = 4'd0;
	localparam logic [REG_IDX_W-1:0] PORT_ENB = 4'd1;
	localparam logic [REG_IDX_W-1:0] PORT_SEL = 4'd2;
	localparam logic [REG_IDX_W-1:0] PORT_INP = 4'd3; // Read only

	// Timer offsets
	localparam logic [REG_IDX_W-1:0] TIM_CTRL   = 4'd0; // Run bit 0, one-shot bit 1
	localparam logic [REG_IDX_W-1:0] TIM_PERIOD = 4'd1;
	localparam logic [REG_IDX_W-1:0] TIM_CMPA   = 4'd2;
	localparam logic [REG_IDX_W-1:0] TIM_CMPB   = 4'd3;
	localparam logic [REG_IDX_W-1:0] TIM_COUNT  = 4'd4; // Live count, read only
	localparam logic [REG_IDX_W-1:0] TIM_FLAGS  = 4'd5; // Write one to clear
	localparam logic [REG_IDX_W-1:0] TIM_PRESC  = 4'd6;

	// Identification values
	localparam logic [DATA_W-1:0] ID_CODE = 16'h1130;
	localparam logic [DATA_W-1:0] VERSION = 16'h0148;
	localparam logic [DATA_W-1:0] CLK_KHZ = 16'd24000; // 24 MHz system clock

	typedef struct packed {
		logic rd; // Read strobe, one cycle
		logic wr; // Write strobe, one cycle
		logic [UNIT_ADR_W+REG_IDX_W-1:0] adr;
		logic [DATA_W-1:0] dat; // Write data
	} bus_req_t;

	typedef struct packed {
		logic idrg;
		logic port;
		logic tim0;
	} unit_sel_t;

	typedef struct packed {
		logic ovf; // Count wrapped to zero, flag bit 2
		logic cma; // Count reached CMPA, flag bit 1
		logic cmb; // Count reached CMPB, flag bit 0
	} tim_evt_t;

	typedef enum logic [1:0] {
		IDLE = 2'd0,
		RUN  = 2'd1,
		DONE = 2'd2 // One-shot finished
	} tim_state_t;

	typedef struct packed {
		logic [PORT_PAD_W-1:0] out; // Pad output value
		logic [PORT_PAD_W-1:0] enb; // Pad drive enable, 0 is high-Z
	} port_pads_t;

endpackage

`default_nettype wire

//--- tb_cases.txt
# op arg1 arg2, all hex: W adr data | R adr expected | P pins 0 | I level 0
# C cycles expected_pwma_highs
R 0100 1130
R 0101 0148
R 0102 5dc0
R 0103 0000
R 0230 0000
R 0111 0000
R 0112 00ff
R 0120 0000
R 0125 0000
I 0000 0000
P a55a 0000
R 0113 005a
W 0112 000f
P a55a 0000
R 0113 00aa
W 0110 00c3
W 0111 00f0
W 0112 00f0
P a55a 0000
R 0113 00c5
R 0110 00c3
R 0111 00f0
P 3c00 0000
R 0113 00cc
W 0112 00ff
P 3c00 0000
R 0113 00c0
# Free running timer, period 9, cmpa 3, cmpb 5
W 0121 0009
W 0122 0003
W 0123 0005
W 0120 0001
C 0014 0006
C 001e 0009
R 0120 0005
R 0125 0007
I 0001 0000
W 0120 0000
P 3c00 0000
R 0120 0000
R 0124 0000
W 0125 0007
R 0125 0000
I 0000 0000
# One-shot with prescale 1
W 0126 0001
W 0120 0003
C 0020 0006
R 0120 000b
R 0124 0000
C 0014 0000
R 0125 0007
W 0125 0007
I 0000 0000
W 0120 0000
P 3c00 0000
R 0120 0000
R 0126 0001

//--- tb_periph_top.sv
`timescale 1ns/1ns
`default_nettype none

module tb_periph_top import soc_pkg::*; ();

	localparam int PORT_W = 8; // Same widths as the DUT defaults
	localparam int CNT_W = 16;
	localparam string CASES_FILE = "tb_cases.txt";

	logic clk;
	logic rst_i;
	bus_req_t bus_req; // Master side of the bus
	logic [2*PORT_W-1:0] ext_pins; // Values driven from outside the chip
	logic [2*PORT_W-1:0] port_pin; // Resolved pad levels
	logic [DATA_W-1:0] bdatr;
	port_pads_t pads;
	logic pwma;
	logic pwmb;
	logic irq;

	logic [7:0] op_q[$]; // Parsed cases
	logic [15:0] arg1_q[$];
	logic [15:0] arg2_q[$];
	logic [15:0] cmpa_wr; // Last CMPA written by the master
	logic [15:0] cmpb_wr; // Last CMPB written by the master
	int unsigned cyc_cnt = 0;
	int unsigned cyc_limit = 100; // Replaced once the cases are loaded

	// Low pads shared with the port drivers
	assign port_pin[PORT_W-1:0] = (pads.out & pads.enb) | (ext_pins[PORT_W-1:0] & ~pads.enb);
	assign port_pin[2*PORT_W-1:PORT_W] = ext_pins[2*PORT_W-1:PORT_W]; // Input only

	periph_top #(
		.PORT_W(PORT_W),
		.CNT_W(CNT_W)
	) i_dut (
		.clk(clk),
		.rst_i(rst_i),
		.bus_req_i(bus_req),
		.bdatr_o(bdatr),
		.port_pin_i(port_pin),
		.port_pads_o(pads),
		.tim0_pwma_o(pwma),
		.tim0_pwmb_o(pwmb),
		.tim0_irq_o(irq)
	);

	always #5 clk = ~clk; // 10 ns period

	task automatic abort_run();
		$display("TEST FAILED");
		$fatal(1, "Simulation stopped at first error");
	endtask

	task automatic check_value(input string name, input logic [15:0] got,
			input logic [15:0] exp);
		if (got !== exp) begin
			$display("Mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
			abort_run();
		end
	endtask

	// Bus tasks start and end on a falling edge
	task automatic bus_write(input logic [15:0] adr, input logic [15:0] dat);
		bus_req = {1'b0, 1'b1, adr, dat}; // rd, wr, adr, dat
		@(negedge clk);
		bus_req = '0;
	endtask

	task automatic bus_read(input logic [15:0] adr, input logic [15:0] exp);
		bus_req = {1'b1, 1'b0, adr, 16'h0000};
		@(negedge clk); // Registered data is out one cycle later
		bus_req = '0;
		check_value($sformatf("bdatr_o at %h", adr), bdatr, exp);
	endtask

	task automatic set_pins(input logic [15:0] pins);
		ext_pins = pins;
		@(negedge clk); // Lets the port sample the new pads
	endtask

	task automatic count_pwm(input logic [15:0] cycles, input logic [15:0] exp);
		int highs_a;
		int highs_b;
		int exp_b;
		highs_a = 0;
		highs_b = 0;
		repeat (cycles) begin
			@(negedge clk);
			if (pwma) begin
				highs_a++;
			end
			if (pwmb) begin
				highs_b++;
			end
		end
		check_value("tim0_pwma_o high cycles", highs_a[15:0], exp);
		if (cmpa_wr != 0) begin
			// Windows hold whole periods, highs scale with the compare value
			exp_b = int'(exp) * int'(cmpb_wr) / int'(cmpa_wr);
			check_value("tim0_pwmb_o high cycles", highs_b[15:0], exp_b[15:0]);
		end
	endtask

	task automatic load_cases();
		int fd;
		int n;
		string line;
		logic [7:0] op;
		logic [15:0] a;
		logic [15:0] b;
		int unsigned sum;
		sum = 0;
		fd = $fopen(CASES_FILE, "r");
		if (fd == 0) begin
			$display("Cannot open the cases file %s", CASES_FILE);
			abort_run();
		end else begin
			while (!$feof(fd)) begin
				line = "";
				void'($fgets(line, fd));
				if (line.len() >= 2 && line.getc(0) != "#") begin // Skip blanks and notes
					n = $sscanf(line, "%c %h %h", op, a, b);
					if (n != 3) begin
						$display("Malformed line in the cases file: %s", line);
						abort_run();
					end else begin
						op_q.push_back(op);
						arg1_q.push_back(a);
						arg2_q.push_back(b);
						if (op == "C") begin
							sum += a; // Window length
						end else if (op != "I") begin
							sum += 1; // W, R and P take one cycle
						end
					end
				end
			end
			$fclose(fd);
			cyc_limit = sum + 100;
		end
	endtask

	task automatic run_case(input logic [7:0] op, input logic [15:0] a, input logic [15:0] b);
		case (op)
			"W": begin
				bus_write(a, b);
				if (a == {BASE_TIM0, TIM_CMPA}) begin
					cmpa_wr = b;
				end else if (a == {BASE_TIM0, TIM_CMPB}) begin
					cmpb_wr = b;
				end
			end
			"R": bus_read(a, b);
			"P": set_pins(a);
			"C": count_pwm(a, b);
			"I": check_value("tim0_irq_o", {15'b0, irq}, a); // Level right now
			default: begin
				$display("Unknown opcode %c in the cases file", op);
				abort_run();
			end
		endcase
	endtask

	// Run limit
	always @(posedge clk) begin
		cyc_cnt <= cyc_cnt + 1;
		if (cyc_cnt > cyc_limit) begin
			$display("Timeout after %0d cycles, cases did not finish", cyc_cnt);
			abort_run();
		end
	end

	initial begin
		clk = 1'b0;
		rst_i = 1'b1;
		bus_req = '0;
		ext_pins = '0;
		cmpa_wr = '0;
		cmpb_wr = '0;
		load_cases();
		repeat (2) @(negedge clk); // Two reset cycles
		rst_i = 1'b0;
		for (int i = 0; i < op_q.size(); i++) begin
			run_case(op_q[i], arg1_q[i], arg2_q[i]);
		end
		$display("TEST OK");
		$finish;
	end

endmodule

`default_nettype wire

//--- timer_counter.sv
`timescale 1ns/1ns
`default_nettype none

module timer_counter import soc_pkg::*; #(
	parameter int CNT_W = 16
) (
	input wire clk,
	input wire rst_i,
	input wire count_en_i,
	input wire [CNT_W-1:0] presc_i,
	input wire [CNT_W-1:0] period_i,
	input wire [CNT_W-1:0] cmpa_i,
	input wire [CNT_W-1:0] cmpb_i,
	output logic [CNT_W-1:0] count_o,
	output tim_evt_t evt_o,
	output logic pwma_o,
	output logic pwmb_o
);

	logic [CNT_W-1:0] presc_cnt; // Clocks since last tick
	logic [CNT_W-1:0] count_q;
	logic [CNT_W-1:0] count_nxt; // Count after the coming tick
	logic tick; // One every PRESC+1 clocks
	logic wrap; // Count sits at the period

	assign tick = count_en_i && (presc_cnt >= presc_i); // >= survives a smaller PRESC write
	assign wrap = (count_q == period_i);
	assign count_nxt = wrap ? '0 : count_q + 1'b1;

	always_ff @(posedge clk) begin
		if (rst_i || !count_en_i) begin
			presc_cnt <= '0; // Held at zero while stopped
			count_q <= '0;
		end else if (tick) begin
			presc_cnt <= '0;
			count_q <= count_nxt;
		end else begin
			presc_cnt <= presc_cnt + 1'b1;
		end
	end

	// Event pulses last the tick cycle only
	always_comb begin
		evt_o.ovf = tick && wrap;
		evt_o.cma = tick && (count_nxt == cmpa_i);
		evt_o.cmb = tick && (count_nxt == cmpb_i);
	end

	assign pwma_o = count_en_i && (count_q < cmpa_i); // Duty of CMPA out of PERIOD+1
	assign pwmb_o = count_en_i && (count_q < cmpb_i);
	assign count_o = count_q;

	// Once inside the period, the count stays inside while PERIOD is unchanged
	a_cnt_in_period: assert property (@(posedge clk) disable iff (rst_i)
		count_en_i && $past(count_en_i) && $stable(period_i) &&
		$past(count_q <= period_i) |-> count_q <= period_i);

endmodule

`default_nettype wire

//--- timer_fsm.sv
`timescale 1ns/1ns
`default_nettype none

module timer_fsm import soc_pkg::*; (
	input wire clk,
	input wire rst_i,
	input wire run_i,
	input wire oneshot_i,
	input wire ctrl_wr_i,
	input wire ovf_i,
	output logic count_en_o,
	output tim_state_t state_o
);

	tim_state_t state_q;
	tim_state_t state_nxt;

	always_comb begin
		state_nxt = state_q;
		case (state_q)
			IDLE: begin
				if (run_i) begin
					state_nxt = RUN; // Start counting next cycle
				end
			end
			RUN: begin
				if (!run_i) begin
					state_nxt = IDLE; // Stop wins over a same-cycle wrap
				end else if (oneshot_i && ovf_i) begin
					state_nxt = DONE; // Single period finished
				end
			end
			DONE: begin
				if (ctrl_wr_i) begin
					state_nxt = run_i ? RUN : IDLE; // Rearm or park
				end
			end
			default: state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			state_q <= IDLE;
		end else begin
			state_q <= state_nxt;
		end
	end

	assign count_en_o = (state_q == RUN); // Counter cleared in IDLE and DONE
	assign state_o = state_q;

	a_state_legal: assert property (@(posedge clk) disable iff (rst_i)
		state_q inside {IDLE, RUN, DONE});

endmodule

`default_nettype wire

//--- timer_unit.sv
`timescale 1ns/1ns
`default_nettype none

module timer_unit import soc_pkg::*; #(
	parameter int CNT_W = 16
) (
	input wire clk,
	input wire rst_i,
	input wire sel_i,
	input wire rd_i,
	input wire wr_i,
	input wire [REG_IDX_W-1:0] idx_i,
	input wire [DATA_W-1:0] wdat_i,
	output logic pwma_o,
	output logic pwmb_o,
	output logic tim_irq_o,
	output logic [DATA_W-1:0] bdatr_o
);

	logic run_q; // TIM_CTRL bit 0
	logic oneshot_q; // TIM_CTRL bit 1
	logic ctrl_wr_q; // Control write, aligned with the new run bit
	logic [CNT_W-1:0] period_q;
	logic [CNT_W-1:0] cmpa_q;
	logic [CNT_W-1:0] cmpb_q;
	logic [CNT_W-1:0] presc_q;
	logic [CNT_W-1:0] count;
	tim_evt_t flags_q; // Sticky event flags
	tim_evt_t flag_clr; // Write-one-to-clear mask
	tim_evt_t evt;
	tim_state_t state;
	logic count_en;
	logic wr_hit;

	assign wr_hit = sel_i && wr_i;
	assign flag_clr = (wr_hit && idx_i == TIM_FLAGS) ?
		tim_evt_t'(wdat_i[$bits(tim_evt_t)-1:0]) : '0;

	always_ff @(posedge clk) begin
		if (rst_i) begin
			run_q <= 1'b0;
			oneshot_q <= 1'b0;
			ctrl_wr_q <= 1'b0;
			period_q <= '0;
			cmpa_q <= '0;
			cmpb_q <= '0;
			presc_q <= '0;
			flags_q <= '0;
		end else begin
			ctrl_wr_q <= wr_hit && (idx_i == TIM_CTRL);
			flags_q <= tim_evt_t'((flags_q & ~flag_clr) | evt); // New event beats clear
			if (wr_hit) begin
				case (idx_i)
					TIM_CTRL: begin
						run_q <= wdat_i[0];
						oneshot_q <= wdat_i[1];
					end
					TIM_PERIOD: period_q <= wdat_i[CNT_W-1:0];
					TIM_CMPA:   cmpa_q <= wdat_i[CNT_W-1:0];
					TIM_CMPB:   cmpb_q <= wdat_i[CNT_W-1:0];
					TIM_PRESC:  presc_q <= wdat_i[CNT_W-1:0];
					default: ; // COUNT is read only, FLAGS handled above
				endcase
			end
		end
	end

	// Registered read word, state shown in CTRL bits 3:2
	always_ff @(posedge clk) begin
		if (rst_i) begin
			bdatr_o <= '0;
		end else if (sel_i && rd_i) begin
			case (idx_i)
				TIM_CTRL:   bdatr_o <= DATA_W'({state, oneshot_q, run_q});
				TIM_PERIOD: bdatr_o <= DATA_W'(period_q);
				TIM_CMPA:   bdatr_o <= DATA_W'(cmpa_q);
				TIM_CMPB:   bdatr_o <= DATA_W'(cmpb_q);
				TIM_COUNT:  bdatr_o <= DATA_W'(count);
				TIM_FLAGS:  bdatr_o <= DATA_W'(flags_q);
				TIM_PRESC:  bdatr_o <= DATA_W'(presc_q);
				default:    bdatr_o <= '0;
			endcase
		end else begin
			bdatr_o <= '0;
		end
	end

	assign tim_irq_o = |flags_q; // Summary of all pending flags

	timer_fsm i_fsm (
		.clk(clk),
		.rst_i(rst_i),
		.run_i(run_q),
		.oneshot_i(oneshot_q),
		.ctrl_wr_i(ctrl_wr_q),
		.ovf_i(evt.ovf),
		.count_en_o(count_en),
		.state_o(state)
	);

	timer_counter #(
		.CNT_W(CNT_W)
	) i_counter (
		.clk(clk),
		.rst_i(rst_i),
		.count_en_i(count_en),
		.presc_i(presc_q),
		.period_i(period_q),
		.cmpa_i(cmpa_q),
		.cmpb_i(cmpb_q),
		.count_o(count),
		.evt_o(evt),
		.pwma_o(pwma_o),
		.pwmb_o(pwmb_o)
	);

endmodule

`default_nettype wire
